// File: list.f
+incdir+hdl
hdl/procyon_pkg.sv
hdl/procyon_ifc.sv
hdl/fetch.sv
hdl/dispatch.sv
hdl/register_map.sv
hdl/reorder_buffer.sv
hdl/reservation_station.sv
hdl/ieu.sv
hdl/procyon.sv
test/procyon_tb.sv

// File: test/procyon_tb.sv
// Testbench for the core with a random ALU program and in-order retire checks; top is procyon_tb
`timescale 1ns/10ps
`include "procyon_defines.svh"

module procyon_tb import procyon_pkg::*; ();

    localparam int          PROG_LEN       = 200;
    localparam int          TIMEOUT_CYCLES = 40 * PROG_LEN;
    localparam logic [31:0] NOOP_INSN      = 32'h0000_0013;

    logic                           clk;
    logic                           i_arst_n;
    logic [`PCYN_DATA_WIDTH-1:0]    i_ic_insn;
    logic                           i_ic_valid;
    logic [`PCYN_ADDR_WIDTH-1:0]    o_ic_pc;
    logic                           o_ic_en;
    logic                           o_regmap_retire_en;
    logic [`PCYN_REG_IDX_WIDTH-1:0] o_regmap_retire_rdest;
    logic [`PCYN_DATA_WIDTH-1:0]    o_regmap_retire_data;

    logic [31:0]                    prog      [0:PROG_LEN-1];
    logic [`PCYN_REG_IDX_WIDTH-1:0] exp_rdest [0:PROG_LEN-1];
    logic [`PCYN_DATA_WIDTH-1:0]    exp_data  [0:PROG_LEN-1];
    logic [`PCYN_DATA_WIDTH-1:0]    model_regs [0:`PCYN_REG_DEPTH-1];

    procyon procyon_i (
        .clk(clk),
        .i_arst_n(i_arst_n),
        .i_ic_insn(i_ic_insn),
        .i_ic_valid(i_ic_valid),
        .o_ic_pc(o_ic_pc),
        .o_ic_en(o_ic_en),
        .o_regmap_retire_en(o_regmap_retire_en),
        .o_regmap_retire_rdest(o_regmap_retire_rdest),
        .o_regmap_retire_data(o_regmap_retire_data)
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input logic [`PCYN_DATA_WIDTH-1:0] exp,
                              input logic [`PCYN_DATA_WIDTH-1:0] act);
        if (act !== exp)
            abort_run($sformatf("error: %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_rdest(input string name, input logic [`PCYN_REG_IDX_WIDTH-1:0] exp,
                               input logic [`PCYN_REG_IDX_WIDTH-1:0] act);
        if (act !== exp)
            abort_run($sformatf("error: %s expected %0d actual %0d", name, exp, act));
    endtask

    task automatic check_pc(input string name, input logic [`PCYN_ADDR_WIDTH-1:0] exp,
                            input logic [`PCYN_ADDR_WIDTH-1:0] act);
        if (act !== exp)
            abort_run($sformatf("error: %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
            abort_run($sformatf("error: %s expected %b actual %b", name, exp, act));
    endtask

    // Small register range keeps dependence chains dense
    function automatic logic [4:0] pick_reg();
        if ($urandom_range(0, 7) == 0) return 5'($urandom_range(0, 31));
        return 5'($urandom_range(0, 5));
    endfunction

    function automatic logic [31:0] gen_insn();
        insn_t w;
        int    kind;
        kind = $urandom_range(0, 99);
        w    = insn_t'($urandom());
        if (kind < 45) begin
            w.r.opcode = `PCYN_RV_OP;
            w.r.funct3 = 3'($urandom_range(0, 7));
            w.r.funct7 = 7'h00;
            if ((w.r.funct3 == 3'd0 || w.r.funct3 == 3'd5) && $urandom_range(0, 1) == 1)
                w.r.funct7 = 7'h20;
            w.r.rd  = pick_reg();
            w.r.rs1 = pick_reg();
            w.r.rs2 = pick_reg();
        end else if (kind < 92) begin
            w.i.opcode = `PCYN_RV_OPIMM;
            w.i.funct3 = 3'($urandom_range(0, 7));
            w.i.rd     = pick_reg();
            w.i.rs1    = pick_reg();
            if (w.i.funct3 == 3'd1)
                w.i.imm12[11:5] = 7'h00;
            if (w.i.funct3 == 3'd5)
                w.i.imm12[11:5] = ($urandom_range(0, 1) == 1) ? 7'h20 : 7'h00;
        end else begin
            // LUI, branch, load or a multiply encoding
            case ($urandom_range(0, 3))
                0:       w.r.opcode = 7'b0110111;
                1:       w.r.opcode = 7'b1100011;
                2:       w.r.opcode = 7'b0000011;
                default: begin
                    w.r.opcode = `PCYN_RV_OP;
                    w.r.funct7 = 7'h01;
                end
            endcase
        end
        return w;
    endfunction

    function automatic bit is_supported(input insn_t w);
        if (w.r.opcode == `PCYN_RV_OP)
            return (w.r.funct7 == 7'h00) ||
                   (w.r.funct7 == 7'h20 && (w.r.funct3 == 3'd0 || w.r.funct3 == 3'd5));
        if (w.r.opcode == `PCYN_RV_OPIMM) begin
            if (w.r.funct3 == 3'd1) return w.r.funct7 == 7'h00;
            if (w.r.funct3 == 3'd5) return w.r.funct7 == 7'h00 || w.r.funct7 == 7'h20;
            return 1'b1;
        end
        return 1'b0;
    endfunction

    // RV32I integer semantics by funct3
    function automatic logic [31:0] ref_alu(input insn_t w, input logic [31:0] a,
                                            input logic [31:0] rb);
        logic        imm_form;
        logic [31:0] b;
        imm_form = (w.i.opcode == `PCYN_RV_OPIMM);
        b        = imm_form ? {{20{w.i.imm12[11]}}, w.i.imm12} : rb;
        case (w.r.funct3)
            3'd0:    return (!imm_form && w.r.funct7[5]) ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'd0, $signed(a) < $signed(b)};
            3'd3:    return {31'd0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return w.r.funct7[5] ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // Runs the program in order and records what each instruction retires
    function automatic void build_expected();
        insn_t       w;
        logic [31:0] v;
        for (int r = 0; r < `PCYN_REG_DEPTH; r++) model_regs[r] = '0;
        for (int n = 0; n < PROG_LEN; n++) begin
            w = prog[n];
            if (is_supported(w)) begin
                v            = ref_alu(w, model_regs[w.r.rs1], model_regs[w.r.rs2]);
                exp_rdest[n] = w.r.rd;
                exp_data[n]  = v;
                if (w.r.rd != 5'd0) model_regs[w.r.rd] = v;
            end else begin
                exp_rdest[n] = '0;
                exp_data[n]  = '0;
            end
        end
    endfunction

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reset, program setup and instruction memory model
    initial begin
        int idx;
        i_arst_n   = 1'b0;
        i_ic_insn  = NOOP_INSN;
        i_ic_valid = 1'b0;
        void'($urandom(32'hfb56_2203));
        for (int n = 0; n < PROG_LEN; n++) prog[n] = gen_insn();
        build_expected();
        repeat (3) @(posedge clk);
        @(negedge clk);
        i_arst_n = 1'b1;
        forever begin
            idx        = int'(o_ic_pc >> 2);
            i_ic_insn  = (idx < PROG_LEN) ? prog[idx] : NOOP_INSN;
            i_ic_valid = ($urandom_range(0, 3) != 0);
            @(negedge clk);
        end
    end

    initial begin
        int cycles;
        int fetched;
        int retired;
        cycles  = 0;
        fetched = 0;
        retired = 0;
        @(posedge i_arst_n);
        while (retired < PROG_LEN) begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES)
                abort_run($sformatf("timeout after %0d cycles with %0d of %0d retired",
                                    TIMEOUT_CYCLES, retired, PROG_LEN));
            if (fetched == 0) begin
                check_flag("ic_en after reset", 1'b1, o_ic_en);
                check_pc("pc before first fetch", '0, o_ic_pc);
                check_flag("retire before first fetch", 1'b0, o_regmap_retire_en);
            end
            if (o_ic_en && i_ic_valid) begin
                check_pc($sformatf("fetch %0d pc", fetched), 32'(fetched * 4), o_ic_pc);
                fetched++;
            end
            if (o_regmap_retire_en) begin
                check_rdest($sformatf("retire %0d rdest", retired), exp_rdest[retired],
                            o_regmap_retire_rdest);
                check_data($sformatf("retire %0d data", retired), exp_data[retired],
                           o_regmap_retire_data);
                retired++;
            end
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: hdl/procyon.sv
// Top level of the out-of-order RV32I integer core; connects fetch through retirement
`timescale 1ns/10ps
`include "procyon_defines.svh"

module procyon import procyon_pkg::*; (
    input  logic                           clk,
    input  logic                           i_arst_n,
    input  logic [`PCYN_DATA_WIDTH-1:0]    i_ic_insn,
    input  logic                           i_ic_valid,
    output logic [`PCYN_ADDR_WIDTH-1:0]    o_ic_pc,
    output logic                           o_ic_en,
    output logic                           o_regmap_retire_en,
    output logic [`PCYN_REG_IDX_WIDTH-1:0] o_regmap_retire_rdest,
    output logic [`PCYN_DATA_WIDTH-1:0]    o_regmap_retire_data
);

    logic                           dispatch_valid;
    insn_t                          dispatch_insn;
    logic                           dispatch_stall;
    logic                           rob_full;
    logic                           rs_full;

    logic                           fu_valid;
    logic [`PCYN_OPCODE_WIDTH-1:0]  fu_opcode;
    insn_t                          fu_insn;
    logic [`PCYN_DATA_WIDTH-1:0]    fu_src_a;
    logic [`PCYN_DATA_WIDTH-1:0]    fu_src_b;
    logic [`PCYN_ROB_IDX_WIDTH-1:0] fu_tag;

    // Common data bus
    logic                           cdb_en;
    logic [`PCYN_ROB_IDX_WIDTH-1:0] cdb_tag;
    logic [`PCYN_DATA_WIDTH-1:0]    cdb_data;

    regmap_if      regmap_bus ();
    rs_dispatch_if rs_bus ();
    retire_if      retire_bus ();

    assign o_regmap_retire_en    = retire_bus.en;
    assign o_regmap_retire_rdest = retire_bus.rdest;
    assign o_regmap_retire_data  = retire_bus.data;

    fetch fetch_inst (
        .clk(clk),
        .i_arst_n(i_arst_n),
        .i_ic_insn(i_ic_insn),
        .i_ic_valid(i_ic_valid),
        .i_dispatch_stall(dispatch_stall),
        .o_ic_pc(o_ic_pc),
        .o_ic_en(o_ic_en),
        .o_dispatch_valid(dispatch_valid),
        .o_dispatch_pc(),
        .o_dispatch_insn(dispatch_insn)
    );

    dispatch dispatch_inst (
        .i_dispatch_valid(dispatch_valid),
        .i_dispatch_insn(dispatch_insn),
        .i_rob_full(rob_full),
        .i_rs_full(rs_full),
        .o_dispatch_stall(dispatch_stall),
        .regmap(regmap_bus.dispatch),
        .rs_disp(rs_bus.dispatch)
    );

    register_map register_map_inst (
        .clk(clk),
        .i_arst_n(i_arst_n),
        .regmap(regmap_bus.regmap),
        .retire(retire_bus.regmap)
    );

    reorder_buffer #(
        .OPTN_ROB_DEPTH(`PCYN_ROB_DEPTH)
    ) rob_inst (
        .clk(clk),
        .i_arst_n(i_arst_n),
        .i_cdb_en(cdb_en),
        .i_cdb_tag(cdb_tag),
        .i_cdb_data(cdb_data),
        .i_rdest(regmap_bus.rename_rdest),
        .o_rob_full(rob_full),
        .regmap(regmap_bus.rob),
        .rs_disp(rs_bus.rob),
        .retire(retire_bus.rob)
    );

    reservation_station #(
        .OPTN_RS_DEPTH(`PCYN_RS_DEPTH)
    ) rs_ieu_inst (
        .clk(clk),
        .i_arst_n(i_arst_n),
        .i_cdb_en(cdb_en),
        .i_cdb_tag(cdb_tag),
        .i_cdb_data(cdb_data),
        .rs_disp(rs_bus.rs),
        .o_rs_full(rs_full),
        .o_fu_valid(fu_valid),
        .o_fu_opcode(fu_opcode),
        .o_fu_insn(fu_insn),
        .o_fu_src_a(fu_src_a),
        .o_fu_src_b(fu_src_b),
        .o_fu_tag(fu_tag)
    );

    ieu ieu_inst (
        .clk(clk),
        .i_arst_n(i_arst_n),
        .i_fu_valid(fu_valid),
        .i_fu_opcode(fu_opcode),
        .i_fu_insn(fu_insn),
        .i_fu_src_a(fu_src_a),
        .i_fu_src_b(fu_src_b),
        .i_fu_tag(fu_tag),
        .o_cdb_en(cdb_en),
        .o_cdb_tag(cdb_tag),
        .o_cdb_data(cdb_data)
    );

endmodule

// File: hdl/ieu.sv
// Integer ALU; registers each result and broadcasts it on the common data bus
`timescale 1ns/10ps
`include "procyon_defines.svh"

module ieu import procyon_pkg::*; (
    input  logic                           clk,
    input  logic                           i_arst_n,
    input  logic                           i_fu_valid,
    input  logic [`PCYN_OPCODE_WIDTH-1:0]  i_fu_opcode,
    input  insn_t                          i_fu_insn,
    input  logic [`PCYN_DATA_WIDTH-1:0]    i_fu_src_a,
    input  logic [`PCYN_DATA_WIDTH-1:0]    i_fu_src_b,
    input  logic [`PCYN_ROB_IDX_WIDTH-1:0] i_fu_tag,
    output logic                           o_cdb_en,
    output logic [`PCYN_ROB_IDX_WIDTH-1:0] o_cdb_tag,
    output logic [`PCYN_DATA_WIDTH-1:0]    o_cdb_data
);

    logic [`PCYN_DATA_WIDTH-1:0] op_b;
    logic [4:0]                  shamt;
    logic [`PCYN_DATA_WIDTH-1:0] result;

    assign op_b  = (i_fu_insn.i.opcode == `PCYN_RV_OPIMM) ?
                   {{(`PCYN_DATA_WIDTH-12){i_fu_insn.i.imm12[11]}}, i_fu_insn.i.imm12} :
                   i_fu_src_b;
    assign shamt = op_b[4:0];

    always_comb begin
        case (i_fu_opcode)
            `PCYN_OP_SUB:  result = i_fu_src_a - op_b;
            `PCYN_OP_AND:  result = i_fu_src_a & op_b;
            `PCYN_OP_OR:   result = i_fu_src_a | op_b;
            `PCYN_OP_XOR:  result = i_fu_src_a ^ op_b;
            `PCYN_OP_SLL:  result = i_fu_src_a << shamt;
            `PCYN_OP_SRL:  result = i_fu_src_a >> shamt;
            `PCYN_OP_SRA:  result = $signed(i_fu_src_a) >>> shamt;
            `PCYN_OP_SLT:  result = `PCYN_DATA_WIDTH'($signed(i_fu_src_a) < $signed(op_b));
            `PCYN_OP_SLTU: result = `PCYN_DATA_WIDTH'(i_fu_src_a < op_b);
            default:       result = i_fu_src_a + op_b;
        endcase
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) o_cdb_en <= 1'b0;
        else           o_cdb_en <= i_fu_valid;
    end

    always_ff @(posedge clk) begin
        o_cdb_tag  <= i_fu_tag;
        o_cdb_data <= result;
    end

endmodule

// File: hdl/reservation_station.sv
// Holds dispatched operations until their operands arrive, then issues one per cycle
`timescale 1ns/10ps
`include "procyon_defines.svh"

module reservation_station import procyon_pkg::*; #(
    parameter OPTN_RS_DEPTH = `PCYN_RS_DEPTH
)(
    input  logic                           clk,
    input  logic                           i_arst_n,
    input  logic                           i_cdb_en,
    input  logic [`PCYN_ROB_IDX_WIDTH-1:0] i_cdb_tag,
    input  logic [`PCYN_DATA_WIDTH-1:0]    i_cdb_data,
    rs_dispatch_if.rs                      rs_disp,
    output logic                           o_rs_full,
    output logic                           o_fu_valid,
    output logic [`PCYN_OPCODE_WIDTH-1:0]  o_fu_opcode,
    output insn_t                          o_fu_insn,
    output logic [`PCYN_DATA_WIDTH-1:0]    o_fu_src_a,
    output logic [`PCYN_DATA_WIDTH-1:0]    o_fu_src_b,
    output logic [`PCYN_ROB_IDX_WIDTH-1:0] o_fu_tag
);

    localparam RS_IDX_WIDTH = $clog2(OPTN_RS_DEPTH);

    logic [OPTN_RS_DEPTH-1:0]       ent_valid;
    logic [1:0]                     ent_rdy  [0:OPTN_RS_DEPTH-1];
    logic [`PCYN_ROB_IDX_WIDTH-1:0] ent_src  [0:OPTN_RS_DEPTH-1][0:1];
    logic [`PCYN_DATA_WIDTH-1:0]    ent_data [0:OPTN_RS_DEPTH-1][0:1];
    logic [`PCYN_OPCODE_WIDTH-1:0]  ent_op   [0:OPTN_RS_DEPTH-1];
    insn_t                          ent_insn [0:OPTN_RS_DEPTH-1];
    logic [`PCYN_ROB_IDX_WIDTH-1:0] ent_dst  [0:OPTN_RS_DEPTH-1];
    logic [RS_IDX_WIDTH-1:0]        free_idx;
    logic [RS_IDX_WIDTH-1:0]        iss_idx;

    assign o_rs_full = &ent_valid;

    // Lowest free slot and lowest ready slot
    always_comb begin
        free_idx   = '0;
        iss_idx    = '0;
        o_fu_valid = 1'b0;
        for (int i = OPTN_RS_DEPTH - 1; i >= 0; i--) begin
            if (!ent_valid[i]) free_idx = RS_IDX_WIDTH'(i);
            if (ent_valid[i] && (ent_rdy[i] == 2'b11)) begin
                iss_idx    = RS_IDX_WIDTH'(i);
                o_fu_valid = 1'b1;
            end
        end
    end

    assign o_fu_opcode = ent_op[iss_idx];
    assign o_fu_insn   = ent_insn[iss_idx];
    assign o_fu_src_a  = ent_data[iss_idx][0];
    assign o_fu_src_b  = ent_data[iss_idx][1];
    assign o_fu_tag    = ent_dst[iss_idx];

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            ent_valid <= '0;
        end else begin
            if (o_fu_valid) ent_valid[iss_idx] <= 1'b0;
            if (rs_disp.en) ent_valid[free_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < OPTN_RS_DEPTH; i++) begin
            for (int s = 0; s < 2; s++) begin
                if (i_cdb_en && !ent_rdy[i][s] && (ent_src[i][s] == i_cdb_tag)) begin
                    ent_rdy[i][s]  <= 1'b1;
                    ent_data[i][s] <= i_cdb_data;
                end
            end
        end
        if (rs_disp.en) begin
            ent_op[free_idx]   <= rs_disp.opcode;
            ent_insn[free_idx] <= rs_disp.insn;
            ent_dst[free_idx]  <= rs_disp.dst_tag;
            for (int s = 0; s < 2; s++) begin
                ent_rdy[free_idx][s]  <= rs_disp.src_rdy[s];
                ent_src[free_idx][s]  <= rs_disp.src_tag[s];
                ent_data[free_idx][s] <= rs_disp.src_data[s];
            end
        end
    end

    assert property (@(posedge clk) disable iff (!i_arst_n) rs_disp.en |-> !o_rs_full);

endmodule

// File: hdl/reorder_buffer.sv
// Circular tag buffer that resolves source operands, records bus results and retires in order
`timescale 1ns/10ps
`include "procyon_defines.svh"

module reorder_buffer #(
    parameter OPTN_ROB_DEPTH = `PCYN_ROB_DEPTH
)(
    input  logic                           clk,
    input  logic                           i_arst_n,
    input  logic                           i_cdb_en,
    input  logic [`PCYN_ROB_IDX_WIDTH-1:0] i_cdb_tag,
    input  logic [`PCYN_DATA_WIDTH-1:0]    i_cdb_data,
    input  logic [`PCYN_REG_IDX_WIDTH-1:0] i_rdest,
    output logic                           o_rob_full,
    regmap_if.rob                          regmap,
    rs_dispatch_if.rob                     rs_disp,
    retire_if.rob                          retire
);

    localparam ROB_IDX_WIDTH = $clog2(OPTN_ROB_DEPTH);

    logic [ROB_IDX_WIDTH-1:0]       head;
    logic [ROB_IDX_WIDTH-1:0]       tail;
    logic [ROB_IDX_WIDTH:0]         count;
    logic [OPTN_ROB_DEPTH-1:0]      ent_done;
    logic [`PCYN_REG_IDX_WIDTH-1:0] ent_rdest [0:OPTN_ROB_DEPTH-1];
    logic [`PCYN_DATA_WIDTH-1:0]    ent_data  [0:OPTN_ROB_DEPTH-1];
    logic                           enq;

    assign enq               = regmap.rename_en;
    assign o_rob_full        = (count == (ROB_IDX_WIDTH+1)'(OPTN_ROB_DEPTH));
    assign regmap.rename_tag = tail;

    assign retire.en    = (count != '0) && ent_done[head];
    assign retire.rdest = ent_rdest[head];
    assign retire.tag   = head;
    assign retire.data  = ent_data[head];

    // Pending register values come from finished entries or the bus this cycle
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            rs_disp.src_rdy[i]  = regmap.rdy[i];
            rs_disp.src_tag[i]  = regmap.tag[i];
            rs_disp.src_data[i] = regmap.data[i];
            if (!regmap.rdy[i]) begin
                if (ent_done[regmap.tag[i]]) begin
                    rs_disp.src_rdy[i]  = 1'b1;
                    rs_disp.src_data[i] = ent_data[regmap.tag[i]];
                end else if (i_cdb_en && (i_cdb_tag == regmap.tag[i])) begin
                    rs_disp.src_rdy[i]  = 1'b1;
                    rs_disp.src_data[i] = i_cdb_data;
                end
            end
        end
        if (rs_disp.rdy_ovrd) rs_disp.src_rdy[1] = 1'b1;
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            head     <= '0;
            tail     <= '0;
            count    <= '0;
            ent_done <= '0;
        end else begin
            if (i_cdb_en) ent_done[i_cdb_tag] <= 1'b1;
            if (enq) begin
                ent_done[tail] <= 1'b0;
                tail           <= tail + 1'b1;
            end
            if (retire.en) head <= head + 1'b1;
            count <= count + (ROB_IDX_WIDTH+1)'(enq) - (ROB_IDX_WIDTH+1)'(retire.en);
        end
    end

    always_ff @(posedge clk) begin
        if (i_cdb_en) ent_data[i_cdb_tag] <= i_cdb_data;
        if (enq) ent_rdest[tail] <= i_rdest;
    end

    // Dispatch must honour the full flag
    assert property (@(posedge clk) disable iff (!i_arst_n) enq |-> !o_rob_full);

    // A result only completes a pending entry, so the head never retires early
    assert property (@(posedge clk) disable iff (!i_arst_n)
        i_cdb_en |-> (count != '0) && !ent_done[i_cdb_tag]);

endmodule

// File: hdl/register_map.sv
// Architectural register file with ready flags and producer tags for renaming
`timescale 1ns/10ps
`include "procyon_defines.svh"

module register_map (
    input  logic       clk,
    input  logic       i_arst_n,
    regmap_if.regmap   regmap,
    retire_if.regmap   retire
);

    logic [`PCYN_DATA_WIDTH-1:0]    reg_data [0:`PCYN_REG_DEPTH-1];
    logic                           reg_rdy  [0:`PCYN_REG_DEPTH-1];
    logic [`PCYN_ROB_IDX_WIDTH-1:0] reg_tag  [0:`PCYN_REG_DEPTH-1];
    logic                           retire_wr;
    logic                           rename_wr;

    // x0 is never written so it stays ready at zero
    assign retire_wr = retire.en && (retire.rdest != '0);
    assign rename_wr = regmap.rename_en && (regmap.rename_rdest != '0);

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            regmap.rdy[i]  = reg_rdy[regmap.rsrc[i]];
            regmap.tag[i]  = reg_tag[regmap.rsrc[i]];
            regmap.data[i] = reg_data[regmap.rsrc[i]];
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < `PCYN_REG_DEPTH; i++) begin
                reg_rdy[i]  <= 1'b1;
                reg_data[i] <= '0;
            end
        end else begin
            if (retire_wr) begin
                reg_data[retire.rdest] <= retire.data;
                // Only the latest producer frees the register
                if (retire.tag == reg_tag[retire.rdest]) reg_rdy[retire.rdest] <= 1'b1;
            end
            if (rename_wr) reg_rdy[regmap.rename_rdest] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rename_wr) reg_tag[regmap.rename_rdest] <= regmap.rename_tag;
    end

endmodule

// File: hdl/dispatch.sv
// Decodes the held instruction, renames its destination and writes it into the station
`timescale 1ns/10ps
`include "procyon_defines.svh"

module dispatch import procyon_pkg::*; (
    input  logic               i_dispatch_valid,
    input  insn_t              i_dispatch_insn,
    input  logic               i_rob_full,
    input  logic               i_rs_full,
    output logic               o_dispatch_stall,
    regmap_if.dispatch         regmap,
    rs_dispatch_if.dispatch    rs_disp
);

    localparam logic [31:0] NOOP_INSN = 32'h0000_0013;

    logic                          is_op;
    logic                          is_imm;
    logic                          f7_zero;
    logic                          f7_alt;
    logic                          legal;
    logic [`PCYN_OPCODE_WIDTH-1:0] alu_op;
    insn_t                         insn;
    logic                          fire;

    assign is_op   = (i_dispatch_insn.r.opcode == `PCYN_RV_OP);
    assign is_imm  = (i_dispatch_insn.r.opcode == `PCYN_RV_OPIMM);
    assign f7_zero = (i_dispatch_insn.r.funct7 == 7'b000_0000);
    assign f7_alt  = (i_dispatch_insn.r.funct7 == 7'b010_0000);

    always_comb begin
        alu_op = `PCYN_OP_ADD;
        legal  = 1'b0;
        if (is_op || is_imm) begin
            case (i_dispatch_insn.r.funct3)
                3'b000: begin
                    alu_op = (is_op && f7_alt) ? `PCYN_OP_SUB : `PCYN_OP_ADD;
                    legal  = is_imm || f7_zero || f7_alt;
                end
                3'b001: begin
                    alu_op = `PCYN_OP_SLL;
                    legal  = f7_zero;
                end
                3'b010: begin
                    alu_op = `PCYN_OP_SLT;
                    legal  = is_imm || f7_zero;
                end
                3'b011: begin
                    alu_op = `PCYN_OP_SLTU;
                    legal  = is_imm || f7_zero;
                end
                3'b100: begin
                    alu_op = `PCYN_OP_XOR;
                    legal  = is_imm || f7_zero;
                end
                3'b101: begin
                    alu_op = f7_alt ? `PCYN_OP_SRA : `PCYN_OP_SRL;
                    legal  = f7_zero || f7_alt;
                end
                3'b110: begin
                    alu_op = `PCYN_OP_OR;
                    legal  = is_imm || f7_zero;
                end
                default: begin
                    alu_op = `PCYN_OP_AND;
                    legal  = is_imm || f7_zero;
                end
            endcase
        end
    end

    // Anything else becomes ADDI x0, x0, 0
    assign insn = legal ? i_dispatch_insn : insn_t'(NOOP_INSN);

    assign o_dispatch_stall = i_rob_full || i_rs_full;
    assign fire             = i_dispatch_valid && !o_dispatch_stall;

    assign regmap.rsrc[0]      = insn.r.rs1;
    assign regmap.rsrc[1]      = insn.r.rs2;
    assign regmap.rename_en    = fire;
    assign regmap.rename_rdest = insn.r.rd;

    assign rs_disp.en       = fire;
    assign rs_disp.opcode   = legal ? alu_op : `PCYN_OP_ADD;
    assign rs_disp.insn     = insn;
    assign rs_disp.dst_tag  = regmap.rename_tag;
    assign rs_disp.rdy_ovrd = (insn.r.opcode == `PCYN_RV_OPIMM);

endmodule

// File: hdl/fetch.sv
// Program counter and one-entry fetch holding register that feed dispatch
`timescale 1ns/10ps
`include "procyon_defines.svh"

module fetch import procyon_pkg::*; (
    input  logic                        clk,
    input  logic                        i_arst_n,
    input  logic [`PCYN_DATA_WIDTH-1:0] i_ic_insn,
    input  logic                        i_ic_valid,
    input  logic                        i_dispatch_stall,
    output logic [`PCYN_ADDR_WIDTH-1:0] o_ic_pc,
    output logic                        o_ic_en,
    output logic                        o_dispatch_valid,
    output logic [`PCYN_ADDR_WIDTH-1:0] o_dispatch_pc,
    output insn_t                       o_dispatch_insn
);

    logic take;

    // Room when empty or when the held instruction leaves this cycle
    assign o_ic_en = !o_dispatch_valid || !i_dispatch_stall;
    assign take    = o_ic_en && i_ic_valid;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_ic_pc          <= '0;
            o_dispatch_valid <= 1'b0;
        end else if (take) begin
            o_ic_pc          <= o_ic_pc + `PCYN_ADDR_WIDTH'(4);
            o_dispatch_valid <= 1'b1;
        end else if (!i_dispatch_stall) begin
            o_dispatch_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            o_dispatch_pc   <= o_ic_pc;
            o_dispatch_insn <= i_ic_insn;
        end
    end

endmodule

// File: hdl/procyon_ifc.sv
// Internal interfaces for rename lookup, station dispatch and retirement between core blocks
`timescale 1ns/10ps
`include "procyon_defines.svh"

interface regmap_if ();
    logic [`PCYN_REG_IDX_WIDTH-1:0] rsrc [0:1];
    logic                           rename_en;
    logic [`PCYN_REG_IDX_WIDTH-1:0] rename_rdest;
    logic [`PCYN_ROB_IDX_WIDTH-1:0] rename_tag;
    logic                           rdy  [0:1];
    logic [`PCYN_ROB_IDX_WIDTH-1:0] tag  [0:1];
    logic [`PCYN_DATA_WIDTH-1:0]    data [0:1];

    modport dispatch (output rsrc, rename_en, rename_rdest, input rename_tag);
    modport rob (output rename_tag, input rename_en, rdy, tag, data);
    modport regmap (input rsrc, rename_en, rename_rdest, rename_tag, output rdy, tag, data);
endinterface

interface rs_dispatch_if import procyon_pkg::*; ();
    logic                           en;
    logic [`PCYN_OPCODE_WIDTH-1:0]  opcode;
    insn_t                          insn;
    logic [`PCYN_ROB_IDX_WIDTH-1:0] dst_tag;
    logic                           rdy_ovrd;
    logic                           src_rdy  [0:1];
    logic [`PCYN_ROB_IDX_WIDTH-1:0] src_tag  [0:1];
    logic [`PCYN_DATA_WIDTH-1:0]    src_data [0:1];

    modport dispatch (output en, opcode, insn, dst_tag, rdy_ovrd);
    modport rob (input rdy_ovrd, output src_rdy, src_tag, src_data);
    modport rs (input en, opcode, insn, dst_tag, src_rdy, src_tag, src_data);
endinterface

interface retire_if ();
    logic                           en;
    logic [`PCYN_REG_IDX_WIDTH-1:0] rdest;
    logic [`PCYN_ROB_IDX_WIDTH-1:0] tag;
    logic [`PCYN_DATA_WIDTH-1:0]    data;

    modport rob (output en, rdest, tag, data);
    modport regmap (input en, rdest, tag, data);
endinterface

// File: hdl/procyon_pkg.sv
// Instruction word layouts shared by dispatch, the reservation station and the execution unit
package procyon_pkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_r_type_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_i_type_t;

    // Same 32-bit word seen as R-type or I-type
    typedef union packed {
        rv_r_type_t r;
        rv_i_type_t i;
    } insn_t;

endpackage

// File: hdl/procyon_defines.svh
// Core-wide widths, depths and ALU operation codes; include in any file that needs them
`ifndef PROCYON_DEFINES_SVH
`define PROCYON_DEFINES_SVH

`define PCYN_DATA_WIDTH    32
`define PCYN_ADDR_WIDTH    32
`define PCYN_REG_DEPTH     32
`define PCYN_REG_IDX_WIDTH 5
`define PCYN_ROB_DEPTH     8
`define PCYN_ROB_IDX_WIDTH 3
`define PCYN_RS_DEPTH      4

// Internal ALU operation codes
`define PCYN_OPCODE_WIDTH  4
`define PCYN_OP_ADD        4'b0000
`define PCYN_OP_SUB        4'b0001
`define PCYN_OP_AND        4'b0010
`define PCYN_OP_OR         4'b0011
`define PCYN_OP_XOR        4'b0100
`define PCYN_OP_SLL        4'b0101
`define PCYN_OP_SRL        4'b0110
`define PCYN_OP_SRA        4'b0111
`define PCYN_OP_SLT        4'b1000
`define PCYN_OP_SLTU       4'b1001

// RISC-V major opcodes handled by the core
`define PCYN_RV_OP         7'b0110011
`define PCYN_RV_OPIMM      7'b0010011

`endif
